/* verilog/qdrc_macros.svh */
`ifndef QDRC_MACROS_SVH
`define QDRC_MACROS_SVH

// data bits carried on each clock edge.
`define QDRC_DATA_WIDTH 18

// byte-write lanes per edge, each one covering 9 data bits.
`define QDRC_BW_WIDTH 2

`define QDRC_ADDR_WIDTH 19

// fixed latency from a sampled user read strobe to phy_rd_data.
`define QDRC_RD_LAT 8

// longest memory read latency that burst alignment searches for.
// Must stay below QDRC_RD_LAT.
`define QDRC_MAX_SRAM_LAT 6

`define QDRC_TRAIN_ADDR 0

// burst marker words, distinct and not bitwise complements of each other.
`define QDRC_MARK_RISE 18'h2a5c3
`define QDRC_MARK_FALL 18'h0f1e6

`endif

/* verilog/qdrc_bus_pkg.sv */
`include "qdrc_macros.svh"

package qdrc_bus_pkg;

  // everything the controller drives onto the memory pins.
  typedef struct packed {
    logic                          w_n;
    logic                          r_n;
    logic [`QDRC_ADDR_WIDTH-1:0]   sa;
    logic [`QDRC_DATA_WIDTH-1:0]   d_rise;
    logic [`QDRC_DATA_WIDTH-1:0]   d_fall;
    logic [`QDRC_BW_WIDTH-1:0]     bw_n_rise; // active low lane enables.
    logic [`QDRC_BW_WIDTH-1:0]     bw_n_fall;
  } qdr_cmd_t;

  // read data as captured on the two edges.
  typedef struct packed {
    logic [`QDRC_DATA_WIDTH-1:0]   q_rise;
    logic [`QDRC_DATA_WIDTH-1:0]   q_fall;
  } qdr_rdata_t;

  // request from the user side, strobes are single cycle pulses.
  typedef struct packed {
    logic                          wr_strb;
    logic                          rd_strb;
    logic [`QDRC_ADDR_WIDTH-1:0]   addr;
    logic [2*`QDRC_DATA_WIDTH-1:0] wr_data; // low half goes out on the rise edge.
    logic [2*`QDRC_BW_WIDTH-1:0]   wr_ben;  // active high, low half for rise.
  } phy_req_t;

endpackage

/* verilog/qdrc_cal_pkg.sv */
package qdrc_cal_pkg;

  // top level power-up sequence.
  typedef enum logic [3:0] {
    PHY_IDLE        = 4'd0,
    PHY_BIT_ALIGN   = 4'd1,
    PHY_BURST_ALIGN = 4'd2,
    PHY_READY       = 4'd3,
    PHY_FAIL        = 4'd4
  } phy_state_t;

  // shared by the bit and burst aligners.
  typedef enum logic [3:0] {
    AL_IDLE  = 4'd0,
    AL_WRITE = 4'd1,
    AL_READ  = 4'd2,
    AL_WAIT  = 4'd3,
    AL_CHECK = 4'd4,
    AL_DONE  = 4'd5,
    AL_FAIL  = 4'd6
  } align_state_t;

  // both bits are levels that hold until reset.
  typedef struct packed {
    logic done;
    logic fail;
  } cal_status_t;

endpackage

/* verilog/qdrc_phy_sm.sv */
`timescale 1ns/1ps

module qdrc_phy_sm
  import qdrc_cal_pkg::*;
(
  input  logic        clk0,
  input  logic        arst_n,
  input  cal_status_t bit_status,
  input  cal_status_t burst_status,
  output logic        bit_align_start,
  output logic        burst_align_start,
  output logic        phy_rdy,
  output logic        cal_fail,
  output phy_state_t  phy_state_prb
);

  phy_state_t state;

  // the two start outputs are single cycle pulses.
  // ready and fail are sticky until the next reset.
  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state             <= PHY_IDLE;
      bit_align_start   <= 1'b0;
      burst_align_start <= 1'b0;
      phy_rdy           <= 1'b0;
      cal_fail          <= 1'b0;
    end else begin
      bit_align_start   <= 1'b0;
      burst_align_start <= 1'b0;
      case (state)
        PHY_IDLE: begin
          bit_align_start <= 1'b1; // kick off training right after reset.
          state           <= PHY_BIT_ALIGN;
        end
        PHY_BIT_ALIGN: begin
          if (bit_status.fail) begin
            cal_fail <= 1'b1;
            state    <= PHY_FAIL;
          end else if (bit_status.done) begin
            burst_align_start <= 1'b1;
            state             <= PHY_BURST_ALIGN;
          end
        end
        PHY_BURST_ALIGN: begin
          if (burst_status.fail) begin
            cal_fail <= 1'b1;
            state    <= PHY_FAIL;
          end else if (burst_status.done) begin
            phy_rdy <= 1'b1;
            state   <= PHY_READY;
          end
        end
        default: begin
          // READY and FAIL are terminal until reset.
          state <= state;
        end
      endcase
    end
  end

  assign phy_state_prb = state;

endmodule

/* verilog/qdrc_phy_bit_align.sv */
`timescale 1ns/1ps
`include "qdrc_macros.svh"

module qdrc_phy_bit_align
  import qdrc_bus_pkg::*, qdrc_cal_pkg::*;
(
  input  logic         clk0,
  input  logic         arst_n,
  input  logic         bit_align_start,
  input  qdr_rdata_t   rdata,
  output qdr_cmd_t     cmd_bit,
  output cal_status_t  bit_status,
  output qdr_rdata_t   rdata_cal,
  output align_state_t bit_align_state_prb,
  output logic [3:0]   bit_train_error_prb
);

  localparam int DW       = `QDRC_DATA_WIDTH;
  localparam int WAIT_CYC = `QDRC_MAX_SRAM_LAT + 1;
  localparam int CNT_W    = $clog2(WAIT_CYC + 1);

  align_state_t     state;
  logic             pass;       // low for the first pattern, high for the inverse one.
  logic [CNT_W-1:0] wait_cnt;
  logic [DW-1:0]    seen;       // bit showed different values on its two edges.
  logic [DW-1:0]    last_rise;  // rise value of the latest such sample.
  logic [DW-1:0]    ok_first;
  logic [DW-1:0]    swap_first;
  logic [DW-1:0]    swap_mask;
  logic [DW-1:0]    ok_now;
  logic [DW-1:0]    swap_now;
  logic [DW-1:0]    bad_bits;
  logic [4:0]       bad_cnt;

  // pattern is rise all ones on the first pass and all zeros on the second.
  always_comb begin
    ok_now   = seen & (pass ? ~last_rise : last_rise);
    swap_now = seen & (pass ? last_rise : ~last_rise);
    // a bit is good only when both passes agree.
    bad_bits = ~((ok_first & ok_now) | (swap_first & swap_now));
    bad_cnt  = '0;
    for (int i = 0; i < DW; i++) begin
      bad_cnt = bad_cnt + 5'(bad_bits[i]);
    end
  end

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state               <= AL_IDLE;
      pass                <= 1'b0;
      wait_cnt            <= '0;
      seen                <= '0;
      last_rise           <= '0;
      ok_first            <= '0;
      swap_first          <= '0;
      swap_mask           <= '0;
      bit_train_error_prb <= '0;
    end else begin
      case (state)
        AL_IDLE:  if (bit_align_start) state <= AL_WRITE;
        AL_WRITE: state <= AL_READ;
        AL_READ: begin
          seen     <= '0;
          wait_cnt <= '0;
          state    <= AL_WAIT;
        end
        AL_WAIT: begin
          // keep the newest sample where the edges differ, stale data is overwritten.
          for (int i = 0; i < DW; i++) begin
            if (rdata.q_rise[i] != rdata.q_fall[i]) begin
              seen[i]      <= 1'b1;
              last_rise[i] <= rdata.q_rise[i];
            end
          end
          if (wait_cnt == CNT_W'(WAIT_CYC - 1)) state <= AL_CHECK;
          else wait_cnt <= wait_cnt + 1'b1;
        end
        AL_CHECK: begin
          if (!pass) begin
            ok_first   <= ok_now;
            swap_first <= swap_now;
            pass       <= 1'b1;
            state      <= AL_WRITE; // run again with the inverse pattern.
          end else begin
            swap_mask           <= swap_first & swap_now;
            bit_train_error_prb <= (bad_cnt > 5'd15) ? 4'd15 : bad_cnt[3:0];
            state               <= (|bad_bits) ? AL_FAIL : AL_DONE;
          end
        end
        default: state <= state;
      endcase
    end
  end

  // training command is decoded straight from the state.
  always_comb begin
    cmd_bit.w_n       = (state != AL_WRITE);
    cmd_bit.r_n       = (state != AL_READ);
    cmd_bit.sa        = `QDRC_ADDR_WIDTH'(`QDRC_TRAIN_ADDR);
    cmd_bit.d_rise    = {DW{~pass}};
    cmd_bit.d_fall    = {DW{pass}};
    cmd_bit.bw_n_rise = '0;
    cmd_bit.bw_n_fall = '0;
  end

  // registered swap stage, one cycle on the read path.
  always_ff @(posedge clk0) begin
    rdata_cal.q_rise <= (rdata.q_rise & ~swap_mask) | (rdata.q_fall & swap_mask);
    rdata_cal.q_fall <= (rdata.q_fall & ~swap_mask) | (rdata.q_rise & swap_mask);
  end

  assign bit_status.done     = (state == AL_DONE);
  assign bit_status.fail     = (state == AL_FAIL);
  assign bit_align_state_prb = state;

endmodule

/* verilog/qdrc_phy_burst_align.sv */
`timescale 1ns/1ps
`include "qdrc_macros.svh"

module qdrc_phy_burst_align
  import qdrc_bus_pkg::*, qdrc_cal_pkg::*;
(
  input  logic         clk0,
  input  logic         arst_n,
  input  logic         burst_align_start,
  input  qdr_rdata_t   rdata_cal,
  output qdr_cmd_t     cmd_burst,
  output cal_status_t  burst_status,
  output qdr_rdata_t   rdata_done,
  output align_state_t bit_train_state_prb
);

  localparam int RD_LAT   = `QDRC_RD_LAT;
  // memory latency plus the one cycle of the bit-alignment swap stage.
  localparam int WAIT_CYC = `QDRC_MAX_SRAM_LAT + 2;
  localparam int CNT_W    = $clog2(RD_LAT + 1);
  localparam int TAP_W    = $clog2(RD_LAT);

  align_state_t     state;
  logic [CNT_W-1:0] wait_cnt;
  logic [TAP_W-1:0] tap;       // extra delay stages in front of rdata_done.
  logic             mark_hit;
  qdr_rdata_t       dly_q [RD_LAT-1];

  assign mark_hit = (rdata_cal.q_rise == `QDRC_MARK_RISE) &&
                    (rdata_cal.q_fall == `QDRC_MARK_FALL);

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state    <= AL_IDLE;
      wait_cnt <= '0;
      tap      <= '0;
    end else begin
      case (state)
        AL_IDLE:  if (burst_align_start) state <= AL_WRITE;
        AL_WRITE: state <= AL_READ;
        AL_READ: begin
          wait_cnt <= '0;
          state    <= AL_WAIT;
        end
        AL_WAIT: begin
          // marker seen wait_cnt+1 edges after the read was sampled.
          if (mark_hit) begin
            tap   <= TAP_W'(RD_LAT - 1 - int'(wait_cnt));
            state <= AL_DONE;
          end else if (wait_cnt == CNT_W'(WAIT_CYC - 1)) begin
            state <= AL_FAIL;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        default: state <= state;
      endcase
    end
  end

  always_comb begin
    cmd_burst.w_n       = (state != AL_WRITE);
    cmd_burst.r_n       = (state != AL_READ);
    cmd_burst.sa        = `QDRC_ADDR_WIDTH'(`QDRC_TRAIN_ADDR);
    cmd_burst.d_rise    = `QDRC_MARK_RISE;
    cmd_burst.d_fall    = `QDRC_MARK_FALL;
    cmd_burst.bw_n_rise = '0;
    cmd_burst.bw_n_fall = '0;
  end

  // read-data delay line.
  always_ff @(posedge clk0) begin
    dly_q[0] <= rdata_cal;
    for (int i = 1; i < RD_LAT - 1; i++) begin
      dly_q[i] <= dly_q[i-1];
    end
  end

  // tap zero passes the swap stage output straight through.
  always_comb begin
    if (tap == '0) rdata_done = rdata_cal;
    else rdata_done = dly_q[tap - 1'b1];
  end

  assign burst_status.done   = (state == AL_DONE);
  assign burst_status.fail   = (state == AL_FAIL);
  assign bit_train_state_prb = state;

endmodule

/* verilog/qdrc_phy.sv */
`timescale 1ns/1ps
`include "qdrc_macros.svh"

module qdrc_phy
  import qdrc_bus_pkg::*, qdrc_cal_pkg::*;
(
  input  logic                          clk0,
  input  logic                          arst_n,
  input  phy_req_t                      phy_req,
  input  qdr_rdata_t                    rdata,
  output qdr_cmd_t                      cmd,
  output logic [2*`QDRC_DATA_WIDTH-1:0] phy_rd_data,
  output logic                          phy_rdy,
  output logic                          cal_fail,
  output align_state_t                  bit_align_state_prb,
  output align_state_t                  bit_train_state_prb,
  output logic [3:0]                    bit_train_error_prb,
  output phy_state_t                    phy_state_prb
);

  localparam int DW = `QDRC_DATA_WIDTH;
  localparam int BW = `QDRC_BW_WIDTH;

  logic        bit_align_start;
  logic        burst_align_start;
  cal_status_t bit_status;
  cal_status_t burst_status;
  qdr_cmd_t    cmd_bit;
  qdr_cmd_t    cmd_burst;
  qdr_rdata_t  rdata_cal;
  qdr_rdata_t  rdata_done;

  qdrc_phy_sm u_sm (
    .clk0              (clk0),
    .arst_n            (arst_n),
    .bit_status        (bit_status),
    .burst_status      (burst_status),
    .bit_align_start   (bit_align_start),
    .burst_align_start (burst_align_start),
    .phy_rdy           (phy_rdy),
    .cal_fail          (cal_fail),
    .phy_state_prb     (phy_state_prb)
  );

  qdrc_phy_bit_align u_bit_align (
    .clk0                (clk0),
    .arst_n              (arst_n),
    .bit_align_start     (bit_align_start),
    .rdata               (rdata),
    .cmd_bit             (cmd_bit),
    .bit_status          (bit_status),
    .rdata_cal           (rdata_cal),
    .bit_align_state_prb (bit_align_state_prb),
    .bit_train_error_prb (bit_train_error_prb)
  );

  qdrc_phy_burst_align u_burst_align (
    .clk0                (clk0),
    .arst_n              (arst_n),
    .burst_align_start   (burst_align_start),
    .rdata_cal           (rdata_cal),
    .cmd_burst           (cmd_burst),
    .burst_status        (burst_status),
    .rdata_done          (rdata_done),
    .bit_train_state_prb (bit_train_state_prb)
  );

  // training owns the pins until it passes or fails.
  always_comb begin
    if (!bit_status.done && !cal_fail) begin
      cmd = cmd_bit;
    end else if (!burst_status.done && !cal_fail) begin
      cmd = cmd_burst;
    end else begin
      cmd.w_n       = ~phy_req.wr_strb;
      cmd.r_n       = ~phy_req.rd_strb;
      cmd.sa        = phy_req.addr;
      cmd.d_rise    = phy_req.wr_data[DW-1:0];
      cmd.d_fall    = phy_req.wr_data[2*DW-1:DW];
      cmd.bw_n_rise = ~phy_req.wr_ben[BW-1:0];
      cmd.bw_n_fall = ~phy_req.wr_ben[2*BW-1:BW];
    end
  end

  assign phy_rd_data = {rdata_done.q_fall, rdata_done.q_rise}; // fall half on top.

endmodule

/* sim/qdr_sram_model.sv */
`timescale 1ns/1ps
`include "qdrc_macros.svh"

module qdr_sram_model
  import qdrc_bus_pkg::*;
(
  input  logic                        clk,
  input  qdr_cmd_t                    cmd,
  input  int unsigned                 lat,       // 2 to QDRC_MAX_SRAM_LAT.
  input  logic [`QDRC_DATA_WIDTH-1:0] swap_mask, // bits whose edges come back swapped.
  input  logic                        stuck_en,
  output qdr_rdata_t                  rdata
);

  localparam int DW   = `QDRC_DATA_WIDTH;
  localparam int MAXL = `QDRC_MAX_SRAM_LAT;

  logic [2*DW-1:0] mem [logic [`QDRC_ADDR_WIDTH-1:0]]; // fall half on top.
  qdr_rdata_t      pipe [MAXL];
  qdr_rdata_t      raw;

  always @(posedge clk) begin
    logic [2*DW-1:0] word;
    qdr_rdata_t      nxt;
    nxt = '0; // idle cycles return zero on both edges.
    if (!cmd.w_n) begin
      word = mem.exists(cmd.sa) ? mem[cmd.sa] : '0;
      for (int j = 0; j < `QDRC_BW_WIDTH; j++) begin
        if (!cmd.bw_n_rise[j]) word[9*j +: 9] = cmd.d_rise[9*j +: 9];
        if (!cmd.bw_n_fall[j]) word[DW+9*j +: 9] = cmd.d_fall[9*j +: 9];
      end
      mem[cmd.sa] = word;
    end
    if (!cmd.r_n) begin
      word       = mem.exists(cmd.sa) ? mem[cmd.sa] : '0;
      nxt.q_rise = word[DW-1:0];
      nxt.q_fall = word[2*DW-1:DW];
    end
    pipe[0] <= nxt;
    for (int k = 1; k < MAXL; k++) begin
      pipe[k] <= pipe[k-1];
    end
  end

  // the board swaps some bits between edges, and one bit can be stuck low.
  always_comb begin
    raw          = pipe[lat - 1];
    rdata.q_rise = (raw.q_rise & ~swap_mask) | (raw.q_fall & swap_mask);
    rdata.q_fall = (raw.q_fall & ~swap_mask) | (raw.q_rise & swap_mask);
    if (stuck_en) begin
      rdata.q_rise[0] = 1'b0;
      rdata.q_fall[0] = 1'b0;
    end
  end

endmodule

/* sim/qdrc_phy_chk.sv */
`timescale 1ns/1ps

module qdrc_phy_chk
  import qdrc_bus_pkg::*;
(
  input logic     clk0,
  input logic     arst_n,
  input phy_req_t phy_req,
  input qdr_cmd_t cmd,
  input logic     phy_rdy,
  input logic     cal_fail
);

  int unsigned fail_cnt = 0; // number of failed assertions.

  // calibration ends in exactly one of the two states.
  rdy_fail_excl: assert property (@(posedge clk0) !(phy_rdy && cal_fail))
    else begin
      $error("phy_rdy and cal_fail are high together");
      fail_cnt = fail_cnt + 1;
    end

  pins_idle_in_reset: assert property (@(posedge clk0) !arst_n |-> (cmd.w_n && cmd.r_n))
    else begin
      $error("w_n or r_n is low while reset is asserted");
      fail_cnt = fail_cnt + 1;
    end

  // after calibration the write pin follows the user strobe directly.
  user_owns_w_n: assert property (@(posedge clk0) phy_rdy |-> (cmd.w_n == !phy_req.wr_strb))
    else begin
      $error("w_n does not follow the user write strobe");
      fail_cnt = fail_cnt + 1;
    end

  rdy_sticky: assert property (@(posedge clk0) $fell(phy_rdy) |-> !arst_n)
    else begin
      $error("phy_rdy fell without a reset");
      fail_cnt = fail_cnt + 1;
    end

endmodule

/* sim/tb_qdrc_phy.sv */
`timescale 1ns/1ps
`include "qdrc_macros.svh"

module tb_qdrc_phy
  import qdrc_bus_pkg::*, qdrc_cal_pkg::*;
();

  localparam int DW         = `QDRC_DATA_WIDTH;
  localparam int RD_LAT     = `QDRC_RD_LAT;
  localparam int NUM_OPS    = 15;
  localparam int CLK_PERIOD = 40;
  // two calibrations, then each user operation with time to drain its read.
  localparam int LIMIT_CYC  = 2 * 200 + NUM_OPS * (RD_LAT + 2);

  logic            clk0;
  logic            arst_n;
  phy_req_t        phy_req;
  qdr_cmd_t        cmd;
  qdr_rdata_t      rdata;
  logic [2*DW-1:0] phy_rd_data;
  logic            phy_rdy;
  logic            cal_fail;
  align_state_t    bit_state;
  align_state_t    burst_state;
  logic [3:0]      err_prb;
  phy_state_t      phy_state;
  int unsigned     sram_lat;
  logic [DW-1:0]   swap_mask;
  logic            stuck_en;

  int unsigned     cyc = 0;
  int              err_cnt = 0;
  int              tests_run = 0;
  int              tests_failed = 0;
  string           test_name = "";
  logic [2*DW-1:0] ref_mem [logic [`QDRC_ADDR_WIDTH-1:0]];
  logic [2*DW-1:0] exp_q [$];   // expected read data in issue order.
  int unsigned     tag_q [$];   // cycle in which each read was sampled.
  string           name_q [$];

  qdrc_phy dut (
    .clk0                (clk0),
    .arst_n              (arst_n),
    .phy_req             (phy_req),
    .rdata               (rdata),
    .cmd                 (cmd),
    .phy_rd_data         (phy_rd_data),
    .phy_rdy             (phy_rdy),
    .cal_fail            (cal_fail),
    .bit_align_state_prb (bit_state),
    .bit_train_state_prb (burst_state),
    .bit_train_error_prb (err_prb),
    .phy_state_prb       (phy_state)
  );

  qdr_sram_model u_sram (
    .clk       (clk0),
    .cmd       (cmd),
    .lat       (sram_lat),
    .swap_mask (swap_mask),
    .stuck_en  (stuck_en),
    .rdata     (rdata)
  );

  bind qdrc_phy qdrc_phy_chk u_chk (
    .clk0     (clk0),
    .arst_n   (arst_n),
    .phy_req  (phy_req),
    .cmd      (cmd),
    .phy_rdy  (phy_rdy),
    .cal_fail (cal_fail)
  );

  initial begin
    clk0 = 1'b0;
    forever #(CLK_PERIOD / 2) clk0 = ~clk0;
  end

  always @(posedge clk0) cyc <= cyc + 1;

  // reference memory, lane j of the user word covers wr_data[9j+8:9j].
  always @(posedge clk0) begin
    logic [2*DW-1:0] word;
    if (phy_rdy && phy_req.wr_strb) begin
      word = ref_mem.exists(phy_req.addr) ? ref_mem[phy_req.addr] : '0;
      for (int j = 0; j < 2 * `QDRC_BW_WIDTH; j++) begin
        if (phy_req.wr_ben[j]) word[9*j +: 9] = phy_req.wr_data[9*j +: 9];
      end
      ref_mem[phy_req.addr] = word;
    end
    if (phy_rdy && phy_req.rd_strb) begin
      exp_q.push_back(ref_mem.exists(phy_req.addr) ? ref_mem[phy_req.addr] : '0);
      tag_q.push_back(cyc);
      name_q.push_back(test_name);
    end
  end

  // data is stable in the half cycle before the RD_LAT sampling edge.
  always @(negedge clk0) begin
    if (tag_q.size() != 0 && cyc == tag_q[0] + RD_LAT) begin
      assert (phy_rd_data === exp_q[0])
        else report_mismatch(name_q[0], 64'(exp_q[0]), 64'(phy_rd_data));
      void'(exp_q.pop_front());
      void'(tag_q.pop_front());
      void'(name_q.pop_front());
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("mismatch %s expected %0h actual %0h", name, exp, act);
    err_cnt++;
  endtask

  // the status probes must show where calibration ended.
  task automatic check_probes(input phy_state_t exp_phy, input align_state_t exp_bit,
                              input align_state_t exp_burst, input logic [3:0] exp_err);
    assert (phy_state == exp_phy)
      else report_mismatch({test_name, " phy_state_prb"}, 64'(exp_phy), 64'(phy_state));
    assert (bit_state == exp_bit)
      else report_mismatch({test_name, " bit_align_state_prb"}, 64'(exp_bit), 64'(bit_state));
    assert (burst_state == exp_burst)
      else report_mismatch({test_name, " bit_train_state_prb"}, 64'(exp_burst),
                           64'(burst_state));
    assert (err_prb == exp_err)
      else report_mismatch({test_name, " bit_train_error_prb"}, 64'(exp_err), 64'(err_prb));
  endtask

  function automatic logic [2*DW-1:0] rand_word();
    return (2*DW)'({$urandom, $urandom});
  endfunction

  task automatic send_req(input logic wr, input logic rd,
                          input logic [`QDRC_ADDR_WIDTH-1:0] addr,
                          input logic [2*DW-1:0] data,
                          input logic [2*`QDRC_BW_WIDTH-1:0] ben);
    phy_req_t req;
    req.wr_strb = wr;
    req.rd_strb = rd;
    req.addr    = addr;
    req.wr_data = data;
    req.wr_ben  = ben;
    @(posedge clk0);
    phy_req <= req;
  endtask

  task automatic idle_req();
    @(posedge clk0);
    phy_req <= '0;
  endtask

  task automatic wait_cal_end();
    while (!(phy_rdy || cal_fail)) @(negedge clk0);
  endtask

  // waits until every outstanding read has been compared.
  task automatic finish_test(input int errs_before);
    @(negedge clk0);
    while (tag_q.size() != 0) @(negedge clk0);
    tests_run++;
    if (err_cnt != errs_before) tests_failed++;
    $display("test %s %s", test_name, (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    int errs;
    logic [`QDRC_ADDR_WIDTH-1:0] addr;
    void'($urandom(32'hec02));
    sram_lat  = 2 + $urandom % (`QDRC_MAX_SRAM_LAT - 1);
    swap_mask = DW'($urandom);
    stuck_en  = 1'b0;
    phy_req   = '0;
    arst_n    = 1'b0;
    repeat (4) @(posedge clk0);
    arst_n <= 1'b1;

    errs      = err_cnt;
    test_name = "calibration";
    wait_cal_end();
    assert ({phy_rdy, cal_fail} == 2'b10)
      else report_mismatch(test_name, 64'(2'b10), 64'({phy_rdy, cal_fail}));
    check_probes(PHY_READY, AL_DONE, AL_DONE, 4'd0);
    finish_test(errs);

    errs      = err_cnt;
    test_name = "write_read";
    addr      = 19'h00123;
    send_req(1'b1, 1'b0, addr, rand_word(), 4'hf);
    send_req(1'b0, 1'b1, addr, '0, '0);
    idle_req();
    finish_test(errs);

    errs      = err_cnt;
    test_name = "byte_enables";
    addr      = 19'h4a0c1;
    send_req(1'b1, 1'b0, addr, rand_word(), 4'hf);
    send_req(1'b1, 1'b0, addr, rand_word(), 4'b0101); // lane 0 of each edge only.
    send_req(1'b0, 1'b1, addr, '0, '0);
    idle_req();
    finish_test(errs);

    errs      = err_cnt;
    test_name = "pipelined_reads";
    for (int i = 0; i < 4; i++) begin
      send_req(1'b1, 1'b0, 19'(16 + 3 * i), rand_word(), 4'hf);
    end
    for (int i = 0; i < 4; i++) begin
      send_req(1'b0, 1'b1, 19'(16 + 3 * i), '0, '0);
    end
    idle_req();
    finish_test(errs);

    // a stuck bit reads the same on both edges, so bit alignment must fail.
    errs      = err_cnt;
    test_name = "fault_detect";
    addr      = 19'h00456;
    @(posedge clk0);
    stuck_en <= 1'b1;
    arst_n   <= 1'b0;
    repeat (4) @(posedge clk0);
    arst_n <= 1'b1;
    wait_cal_end();
    assert ({phy_rdy, cal_fail} == 2'b01)
      else report_mismatch(test_name, 64'(2'b01), 64'({phy_rdy, cal_fail}));
    check_probes(PHY_FAIL, AL_FAIL, AL_IDLE, 4'd1); // one stuck bit, burst step never ran.
    send_req(1'b1, 1'b0, addr, rand_word(), 4'hf);
    @(negedge clk0);
    assert ({cmd.w_n, cmd.r_n, cmd.sa} == {1'b0, 1'b1, addr})
      else report_mismatch(test_name, 64'({1'b0, 1'b1, addr}), 64'({cmd.w_n, cmd.r_n, cmd.sa}));
    send_req(1'b0, 1'b1, addr, '0, '0);
    @(negedge clk0);
    assert ({cmd.w_n, cmd.r_n, cmd.sa} == {1'b1, 1'b0, addr})
      else report_mismatch(test_name, 64'({1'b1, 1'b0, addr}), 64'({cmd.w_n, cmd.r_n, cmd.sa}));
    idle_req();
    finish_test(errs);

    $display("tests run %0d, tests failed %0d, check errors %0d, assertion errors %0d",
             tests_run, tests_failed, err_cnt, dut.u_chk.fail_cnt);
    if (err_cnt == 0 && dut.u_chk.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYC * CLK_PERIOD);
    $display("timeout, the tests did not finish within %0d cycles", LIMIT_CYC);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* tb.f */
+incdir+verilog
verilog/qdrc_bus_pkg.sv
verilog/qdrc_cal_pkg.sv
verilog/qdrc_phy_sm.sv
verilog/qdrc_phy_bit_align.sv
verilog/qdrc_phy_burst_align.sv
verilog/qdrc_phy.sv
sim/qdr_sram_model.sv
sim/qdrc_phy_chk.sv
sim/tb_qdrc_phy.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_qdrc_phy -f tb.f \
  -o tb_qdrc_phy || { echo "build failed"; exit 1; }
./obj_dir/tb_qdrc_phy +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "run ended without a result"; exit 1; }
exit 0
